/* src/dts_attach_pkg.sv */
`default_nettype none

package dts_attach_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // One antenna's worth of deformatter lanes
  // Register layout below is built around twelve
  localparam int num_lanes = 12;

  // Wishbone data word
  typedef logic [31:0] wb_word_t;

  // Word index, address bits 5..2
  typedef logic [3:0] reg_idx_t;

  // Deformatter control bus address or data byte
  typedef logic [7:0] dts_byte_t;

  // One bit per lane
  typedef logic [num_lanes-1:0] lane_mask_t;

  // Lane mux select, 4 bits per lane
  typedef logic [4*num_lanes-1:0] mux_ctl_t;

  // Signed bit-slip offset, saturates at +/-127
  typedef logic signed [7:0] lane_offset_t;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  // Write starts an access, read gives status
  localparam reg_idx_t reg_control   = 4'd0;
  // Advance, delay and shift reset masks
  localparam reg_idx_t reg_delay     = 4'd1;
  // Mux select, low and high words
  localparam reg_idx_t reg_mux_lo    = 4'd2;
  localparam reg_idx_t reg_mux_hi    = 4'd3;
  localparam reg_idx_t reg_three_bit = 4'd4;
  // Error pulse lane mask
  localparam reg_idx_t reg_error     = 4'd5;
  // Packed lane offsets, four lanes per word
  localparam reg_idx_t reg_offset0   = 4'd6;
  localparam reg_idx_t reg_offset1   = 4'd7;
  localparam reg_idx_t reg_offset2   = 4'd8;

  //////////////////////////////////////////////////
  // Access sequencer
  //////////////////////////////////////////////////

  // Idle, then address setup, strobe run, one hold cycle
  typedef enum logic [1:0] {
    seq_idle,
    seq_setup,
    seq_strobe,
    seq_hold
  } seq_state_t;

endpackage

`default_nettype wire

/* src/wb_reg_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_reg_slave (
  input  wire                                        user_clk,
  input  wire                                        wb_rst_i,
  // Wishbone slave
  input  wire                                        wb_cyc_i,
  input  wire                                        wb_stb_i,
  input  wire                                        wb_we_i,
  input  wire  [31:0]                                wb_adr_i,
  input  wire  [3:0]                                 wb_sel_i,
  input  wire  dts_attach_pkg::wb_word_t             wb_dat_i,
  output logic [31:0]                                wb_dat_o,
  output logic                                       wb_ack_o,
  output logic                                       wb_err_o,
  // Sequencer request
  output logic                                       ctl_start_o,
  output dts_attach_pkg::wb_word_t                   ctl_word_o,
  // Alignment requests
  output logic                                       delay_load_o,
  output dts_attach_pkg::wb_word_t                   delay_word_o,
  output logic                                       error_load_o,
  output dts_attach_pkg::lane_mask_t                 error_mask_o,
  // Status back from both blocks
  input  wire                                        ctl_busy_i,
  input  wire  dts_attach_pkg::dts_byte_t            ctl_rd_data_i,
  input  wire  dts_attach_pkg::lane_mask_t           locked_i,
  input  wire  [8*dts_attach_pkg::num_lanes-1:0]     lane_offsets_i,
  // Settings
  output dts_attach_pkg::mux_ctl_t                   mux_control_o,
  output logic                                       is_three_bit_o
);

  import dts_attach_pkg::*;

  // Bits of the delay word that exist, 30..24 read as zero
  localparam wb_word_t delay_bits = 32'h80FF_FFFF;

  reg_idx_t idx;
  logic     req;
  logic     hold;
  logic     accept;
  logic     wr_acc;
  wb_word_t wmask;
  wb_word_t rd_word;
  wb_word_t old_word;
  wb_word_t wr_word;

  // No bus errors from this slave
  assign wb_err_o = 1'b0;

  assign req = wb_cyc_i && wb_stb_i;
  assign idx = wb_adr_i[5:2];

  // CONTROL write waits out a running access
  assign hold = req && wb_we_i && (idx == reg_control) && ctl_busy_i;

  // Skip the ack cycle itself, else one request acks twice
  assign accept = req && !wb_ack_o && !hold;
  assign wr_acc = accept && wb_we_i;

  // Byte lane enables
  assign wmask = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};

  //////////////////////////////////////////////////
  // Read combiner
  //////////////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    case (idx)
      // Busy, locked lanes, last captured byte
      reg_control:   rd_word = {ctl_busy_i, 11'b0, locked_i, ctl_rd_data_i};
      reg_delay:     rd_word = delay_word_o;
      reg_mux_lo:    rd_word = mux_control_o[31:0];
      reg_mux_hi:    rd_word = wb_word_t'(mux_control_o[47:32]);
      reg_three_bit: rd_word = wb_word_t'(is_three_bit_o);
      reg_error:     rd_word = wb_word_t'(error_mask_o);
      // Lowest lane sits in the lowest byte
      reg_offset0:   rd_word = lane_offsets_i[31:0];
      reg_offset1:   rd_word = lane_offsets_i[63:32];
      reg_offset2:   rd_word = lane_offsets_i[95:64];
      default:       rd_word = '0;
    endcase
  end

  // Partial writes keep the unselected bytes
  // CONTROL reads back status, so merge with the stored word
  assign old_word = (idx == reg_control) ? ctl_word_o : rd_word;
  assign wr_word  = (old_word & ~wmask) | (wb_dat_i & wmask);

  //////////////////////////////////////////////////
  // Ack, strobes and registers
  //////////////////////////////////////////////////

  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      wb_ack_o       <= 1'b0;
      ctl_start_o    <= 1'b0;
      delay_load_o   <= 1'b0;
      error_load_o   <= 1'b0;
      ctl_word_o     <= '0;
      delay_word_o   <= '0;
      error_mask_o   <= '0;
      mux_control_o  <= '0;
      is_three_bit_o <= 1'b0;
    end else begin
      wb_ack_o     <= accept;
      // Load pulses land in the ack cycle
      ctl_start_o  <= wr_acc && (idx == reg_control);
      delay_load_o <= wr_acc && (idx == reg_delay);
      error_load_o <= wr_acc && (idx == reg_error);
      if (wr_acc) begin
        case (idx)
          reg_control:   ctl_word_o <= wr_word;
          reg_delay:     delay_word_o <= wr_word & delay_bits;
          reg_mux_lo:    mux_control_o[31:0] <= wr_word;
          reg_mux_hi:    mux_control_o[47:32] <= wr_word[15:0];
          reg_three_bit: is_three_bit_o <= wr_word[0];
          reg_error:     error_mask_o <= wr_word[num_lanes-1:0];
          default:       ;
        endcase
      end
    end
  end

  // Read word sampled at accept, valid with the ack
  always_ff @(posedge user_clk) begin
    if (accept) begin
      wb_dat_o <= rd_word;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // One ack per request, even with stb still high
  assert property (@(posedge user_clk) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o);

  // Sequencer never restarted mid-access
  assert property (@(posedge user_clk) disable iff (wb_rst_i)
    ctl_start_o |-> !ctl_busy_i);

endmodule

`default_nettype wire

/* src/dts_ctl_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dts_ctl_port #(
  parameter int strobe_len_p = 3
) (
  input  wire                                user_clk,
  input  wire                                wb_rst_i,
  // Request from the register slave
  input  wire                                ctl_start_i,
  input  wire  dts_attach_pkg::wb_word_t     ctl_word_i,
  output logic                               busy_o,
  output dts_attach_pkg::dts_byte_t          rd_data_o,
  output dts_attach_pkg::lane_mask_t         locked_o,
  // Deformatter control bus
  input  wire  dts_attach_pkg::dts_byte_t    data_i,
  input  wire  dts_attach_pkg::lane_mask_t   locked_i,
  output dts_attach_pkg::dts_byte_t          data_o,
  output dts_attach_pkg::dts_byte_t          addr_o,
  output dts_attach_pkg::lane_mask_t         cs_o,
  output logic                               wrst_o,
  output logic                               rdst_o,
  output logic                               unmute_o
);

  import dts_attach_pkg::*;

  // Wide enough to hold strobe_len_p - 1, even for length 1
  localparam int cnt_w = $clog2(strobe_len_p + 1);

  seq_state_t       state_q;
  logic [cnt_w-1:0] cnt_q;
  wb_word_t         word_q;
  logic             is_read;
  logic             is_write;
  logic             in_strobe;
  logic             last_strobe;

  // Read bit wins when both strobes are requested
  assign is_read  = word_q[17];
  assign is_write = word_q[16] && !word_q[17];

  assign in_strobe   = (state_q == seq_strobe);
  assign last_strobe = in_strobe && (cnt_q == cnt_w'(strobe_len_p - 1));

  assign busy_o = (state_q != seq_idle);

  //////////////////////////////////////////////////
  // Bus drive
  //////////////////////////////////////////////////

  assign data_o = word_q[7:0];
  assign addr_o = word_q[15:8];
  // Chips selected from setup through hold only
  assign cs_o   = busy_o ? word_q[30:19] : '0;
  assign wrst_o = in_strobe && is_write;
  assign rdst_o = in_strobe && is_read;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      state_q   <= seq_idle;
      cnt_q     <= '0;
      word_q    <= '0;
      rd_data_o <= '0;
      unmute_o  <= 1'b0;
    end else begin
      case (state_q)
        seq_idle: begin
          if (ctl_start_i) begin
            word_q   <= ctl_word_i;
            // Unmute follows each CONTROL write
            unmute_o <= ctl_word_i[18];
            state_q  <= seq_setup;
          end
        end
        seq_setup: begin
          cnt_q   <= '0;
          state_q <= seq_strobe;
        end
        seq_strobe: begin
          cnt_q <= cnt_q + 1'b1;
          if (last_strobe) begin
            // Deformatter byte valid by the final strobe cycle
            if (is_read) begin
              rd_data_o <= data_i;
            end
            state_q <= seq_hold;
          end
        end
        seq_hold: state_q <= seq_idle;
        default:  state_q <= seq_idle;
      endcase
    end
  end

  // Lock status sampled every cycle
  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      locked_o <= '0;
    end else begin
      locked_o <= locked_i;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  assert property (@(posedge user_clk) disable iff (wb_rst_i)
    !(wrst_o && rdst_o));

endmodule

`default_nettype wire

/* src/lane_align_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_align_ctrl (
  input  wire                                      user_clk,
  input  wire                                      wb_rst_i,
  // Loads from the register slave
  input  wire                                      delay_load_i,
  input  wire  dts_attach_pkg::wb_word_t           delay_word_i,
  input  wire                                      error_load_i,
  input  wire  dts_attach_pkg::lane_mask_t         error_mask_i,
  // Per-lane pulses to the deformatters
  output dts_attach_pkg::lane_mask_t               shift_advance_o,
  output dts_attach_pkg::lane_mask_t               shift_delay_o,
  output dts_attach_pkg::lane_mask_t               induce_error_o,
  output logic                                     shift_rst_o,
  // Offsets, lane 0 in bits 7..0
  output logic [8*dts_attach_pkg::num_lanes-1:0]   lane_offsets_o
);

  import dts_attach_pkg::*;

  localparam lane_offset_t off_max = 8'sd127;
  localparam lane_offset_t off_min = -8'sd127;

  lane_offset_t off_q [num_lanes];
  lane_mask_t   adv;
  lane_mask_t   dly;
  logic         rst_req;

  // Masks count only in the load cycle
  assign adv     = delay_load_i ? delay_word_i[num_lanes-1:0] : '0;
  assign dly     = delay_load_i ? delay_word_i[2*num_lanes-1:num_lanes] : '0;
  assign rst_req = delay_load_i && delay_word_i[31];

  //////////////////////////////////////////////////
  // Pulses
  //////////////////////////////////////////////////

  // High for the single cycle after a load
  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      shift_advance_o <= '0;
      shift_delay_o   <= '0;
      shift_rst_o     <= 1'b0;
      induce_error_o  <= '0;
    end else begin
      shift_advance_o <= adv;
      shift_delay_o   <= dly;
      shift_rst_o     <= rst_req;
      induce_error_o  <= error_load_i ? error_mask_i : '0;
    end
  end

  //////////////////////////////////////////////////
  // Offset counters
  //////////////////////////////////////////////////

  // Same edge as the pulses, so new offsets show with them
  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      for (int i = 0; i < num_lanes; i++) begin
        off_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_lanes; i++) begin
        // Shift reset beats any mask
        if (rst_req) begin
          off_q[i] <= '0;
        // Advance alone, one bit earlier
        end else if (adv[i] && !dly[i] && off_q[i] != off_min) begin
          off_q[i] <= off_q[i] - 8'sd1;
        // Delay alone, one bit later
        end else if (dly[i] && !adv[i] && off_q[i] != off_max) begin
          off_q[i] <= off_q[i] + 8'sd1;
        end
      end
    end
  end

  for (genvar g = 0; g < num_lanes; g++) begin : g_pack
    assign lane_offsets_o[8*g +: 8] = off_q[g];
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Back-to-back loads cannot happen, slave ack leaves a gap
  assert property (@(posedge user_clk) disable iff (wb_rst_i)
    ((shift_advance_o & $past(shift_advance_o)) |
     (shift_delay_o & $past(shift_delay_o)) |
     (induce_error_o & $past(induce_error_o))) == '0);

  assert property (@(posedge user_clk) disable iff (wb_rst_i)
    shift_rst_o |=> !shift_rst_o);

endmodule

`default_nettype wire

/* src/wb_dts_attach.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_dts_attach #(
  parameter int strobe_len_p = 3
) (
  input  wire                                user_clk,
  input  wire                                wb_rst_i,
  // Wishbone slave
  input  wire                                wb_cyc_i,
  input  wire                                wb_stb_i,
  input  wire                                wb_we_i,
  input  wire  [31:0]                        wb_adr_i,
  input  wire  [3:0]                         wb_sel_i,
  input  wire  dts_attach_pkg::wb_word_t     wb_dat_i,
  output wire  dts_attach_pkg::wb_word_t     wb_dat_o,
  output wire                                wb_ack_o,
  output wire                                wb_err_o,
  // Deformatter control bus
  input  wire  dts_attach_pkg::dts_byte_t    data_i,
  output wire  dts_attach_pkg::dts_byte_t    data_o,
  output wire  dts_attach_pkg::dts_byte_t    addr_o,
  output wire  dts_attach_pkg::lane_mask_t   cs_o,
  output wire                                wrst_o,
  output wire                                rdst_o,
  output wire                                unmute_o,
  input  wire  dts_attach_pkg::lane_mask_t   locked_i,
  // Delay control
  output wire  dts_attach_pkg::lane_mask_t   shift_advance_o,
  output wire  dts_attach_pkg::lane_mask_t   shift_delay_o,
  output wire                                shift_rst_o,
  // Mux control
  output wire  dts_attach_pkg::mux_ctl_t     mux_control_o,
  output wire                                is_three_bit_o,
  // Bit error injection
  output wire  dts_attach_pkg::lane_mask_t   induce_error_o
);

  import dts_attach_pkg::*;

  // Slave to sequencer and back
  logic       ctl_start;
  wb_word_t   ctl_word;
  logic       ctl_busy;
  dts_byte_t  ctl_rd_data;
  lane_mask_t locked_q;

  // Slave to alignment and back
  logic                     delay_load;
  wb_word_t                 delay_word;
  logic                     error_load;
  lane_mask_t               error_mask;
  logic [8*num_lanes-1:0]   lane_offsets;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  wb_reg_slave reg_slave_i (
    .user_clk       (user_clk),
    .wb_rst_i       (wb_rst_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_sel_i       (wb_sel_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .wb_err_o       (wb_err_o),
    .ctl_start_o    (ctl_start),
    .ctl_word_o     (ctl_word),
    .delay_load_o   (delay_load),
    .delay_word_o   (delay_word),
    .error_load_o   (error_load),
    .error_mask_o   (error_mask),
    .ctl_busy_i     (ctl_busy),
    .ctl_rd_data_i  (ctl_rd_data),
    .locked_i       (locked_q),
    .lane_offsets_i (lane_offsets),
    .mux_control_o  (mux_control_o),
    .is_three_bit_o (is_three_bit_o)
  );

  //////////////////////////////////////////////////
  // Side-by-side blocks
  //////////////////////////////////////////////////

  dts_ctl_port #(
    .strobe_len_p (strobe_len_p)
  ) ctl_port_i (
    .user_clk    (user_clk),
    .wb_rst_i    (wb_rst_i),
    .ctl_start_i (ctl_start),
    .ctl_word_i  (ctl_word),
    .busy_o      (ctl_busy),
    .rd_data_o   (ctl_rd_data),
    .locked_o    (locked_q),
    .data_i      (data_i),
    .locked_i    (locked_i),
    .data_o      (data_o),
    .addr_o      (addr_o),
    .cs_o        (cs_o),
    .wrst_o      (wrst_o),
    .rdst_o      (rdst_o),
    .unmute_o    (unmute_o)
  );

  lane_align_ctrl lane_align_i (
    .user_clk        (user_clk),
    .wb_rst_i        (wb_rst_i),
    .delay_load_i    (delay_load),
    .delay_word_i    (delay_word),
    .error_load_i    (error_load),
    .error_mask_i    (error_mask),
    .shift_advance_o (shift_advance_o),
    .shift_delay_o   (shift_delay_o),
    .induce_error_o  (induce_error_o),
    .shift_rst_o     (shift_rst_o),
    .lane_offsets_o  (lane_offsets)
  );

endmodule

`default_nettype wire

/* verification/tb_wb_dts_attach.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_dts_attach;

  import dts_attach_pkg::*;

  localparam int strobe_len   = 3;
  localparam int n_access     = 4;
  localparam int n_lane_steps = 600;
  // Bus operations: lane writes, offset reads, accesses with polls, register checks
  localparam int num_ops = n_lane_steps + (n_lane_steps / 4) * 3 + 16 * n_access + 40;
  // Worst op is a held CONTROL write, plus pulse checks
  localparam int op_bound       = strobe_len + 9;
  localparam int timeout_cycles = num_ops * op_bound;

  logic        user_clk = 1'b0;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [3:0]  wb_sel_i;
  wb_word_t    wb_dat_i;
  wb_word_t    wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  dts_byte_t   data_i;
  dts_byte_t   data_o;
  dts_byte_t   addr_o;
  lane_mask_t  cs_o;
  logic        wrst_o;
  logic        rdst_o;
  logic        unmute_o;
  lane_mask_t  locked_i;
  lane_mask_t  shift_advance_o;
  lane_mask_t  shift_delay_o;
  logic        shift_rst_o;
  mux_ctl_t    mux_control_o;
  logic        is_three_bit_o;
  lane_mask_t  induce_error_o;

  int unsigned  cycle = 0;
  int unsigned  last_ack;
  logic         strobe_q = 1'b0;
  logic         starting;
  // One entry per strobe run seen on the control bus
  wb_word_t     acc_q [$];
  lane_offset_t model_off [num_lanes];

  always #2 user_clk = ~user_clk;

  wb_dts_attach #(
    .strobe_len_p (strobe_len)
  ) wb_dts_attach_i (
    .user_clk        (user_clk),
    .wb_rst_i        (wb_rst_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_sel_i        (wb_sel_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .wb_err_o        (wb_err_o),
    .data_i          (data_i),
    .data_o          (data_o),
    .addr_o          (addr_o),
    .cs_o            (cs_o),
    .wrst_o          (wrst_o),
    .rdst_o          (rdst_o),
    .unmute_o        (unmute_o),
    .locked_i        (locked_i),
    .shift_advance_o (shift_advance_o),
    .shift_delay_o   (shift_delay_o),
    .shift_rst_o     (shift_rst_o),
    .mux_control_o   (mux_control_o),
    .is_three_bit_o  (is_three_bit_o),
    .induce_error_o  (induce_error_o)
  );

  //////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////

  // Deformatter register contents, seen through address and chip selects
  function automatic dts_byte_t dts_model_byte(input dts_byte_t addr, input lane_mask_t cs);
    return {addr[3:0], addr[7:4]} ^ cs[7:0] ^ {4'h0, cs[11:8]} ^ 8'hc3;
  endfunction

  // CONTROL read layout: busy 31, locked 19..8, byte 7..0
  function automatic wb_word_t ctl_status_word(input logic busy, input lane_mask_t locked,
                                               input dts_byte_t rd_byte);
    return {busy, 11'b0, locked, rd_byte};
  endfunction

  // Monitor record of one access
  function automatic wb_word_t pack_access(input logic rd, input logic wr, input lane_mask_t cs,
                                           input dts_byte_t addr, input dts_byte_t data);
    return {2'b0, rd, wr, cs, addr, data};
  endfunction

  // Saturating slip rule, reset first
  function automatic lane_offset_t next_offset(input lane_offset_t cur, input logic adv,
                                               input logic dly, input logic rst);
    if (rst) begin
      return '0;
    end else if (adv && !dly && cur > -8'sd127) begin
      return cur - 8'sd1;
    end else if (dly && !adv && cur < 8'sd127) begin
      return cur + 8'sd1;
    end
    return cur;
  endfunction

  function automatic lane_mask_t rnd_mask();
    logic [31:0] r;
    r = $urandom;
    return r[num_lanes-1:0];
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic fail_run();
    $display("TESTS FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_word(input wb_word_t got, input wb_word_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_mask(input lane_mask_t got, input lane_mask_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_offset(input lane_offset_t got, input lane_offset_t exp,
                              input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
      fail_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Wishbone driver
  //////////////////////////////////////////////////

  // Request on a rising edge, ack sampled mid-cycle, released at the end of the ack cycle
  task automatic wb_cycle(input logic we, input reg_idx_t idx, input wb_word_t wdata,
                          output wb_word_t rdata);
    @(posedge user_clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= {26'd0, idx, 2'b00};
    wb_sel_i <= 4'hf;
    wb_dat_i <= wdata;
    @(negedge user_clk);
    while (!wb_ack_o) begin
      @(negedge user_clk);
    end
    rdata    = wb_dat_o;
    last_ack = cycle;
    @(posedge user_clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input reg_idx_t idx, input wb_word_t wdata);
    wb_word_t unused;
    wb_cycle(1'b1, idx, wdata, unused);
  endtask

  task automatic wb_read(input reg_idx_t idx, output wb_word_t rdata);
    wb_cycle(1'b0, idx, '0, rdata);
  endtask

  // Poll CONTROL until the busy bit clears
  task automatic wait_idle();
    wb_word_t w;
    w = '1;
    while (w[31]) begin
      wb_read(reg_control, w);
    end
  endtask

  task automatic expect_access(input wb_word_t exp, input string what);
    wb_word_t got;
    if (acc_q.size() == 0) begin
      $display("No deformatter access seen for %s at %0t ns", what, $time);
      fail_run();
    end else begin
      got = acc_q.pop_front();
      check_word(got, exp, what);
    end
  endtask

  //////////////////////////////////////////////////
  // Deformatter model and bus monitor
  //////////////////////////////////////////////////

  // Byte returned only while the read strobe is up
  assign data_i = rdst_o ? dts_model_byte(addr_o, cs_o) : '0;

  always @(negedge user_clk) begin
    starting = (wrst_o || rdst_o) && !strobe_q;
    strobe_q = wrst_o || rdst_o;
    if (!wb_rst_i) begin
      if (wb_err_o) begin
        $display("Bus error response seen at %0t ns", $time);
        fail_run();
      end else if (wrst_o && rdst_o) begin
        $display("Write and read strobes high together at %0t ns", $time);
        fail_run();
      end else if (starting) begin
        acc_q.push_back(pack_access(rdst_o, wrst_o, cs_o, addr_o, data_o));
      end else if (strobe_q) begin
        // Address, data and selects hold for the whole strobe
        check_word(pack_access(rdst_o, wrst_o, cs_o, addr_o, data_o), acc_q[$],
                   "control bus during strobe");
      end
    end
  end

  // Run length limit
  always @(posedge user_clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("Timeout, run went past %0d cycles", timeout_cycles);
      fail_run();
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic verify_reset_state();
    wb_word_t w;
    @(negedge user_clk);
    check_word({25'b0, wb_ack_o, wb_err_o, wrst_o, rdst_o, shift_rst_o, unmute_o,
                is_three_bit_o}, '0, "single-bit outputs after reset");
    check_mask(cs_o, '0, "chip selects after reset");
    check_mask(shift_advance_o, '0, "advance pulses after reset");
    check_mask(shift_delay_o, '0, "delay pulses after reset");
    check_mask(induce_error_o, '0, "error pulses after reset");
    check_word(mux_control_o[31:0], '0, "mux low after reset");
    check_word({16'b0, mux_control_o[47:32]}, '0, "mux high after reset");
    // Every index, mapped or not
    for (int i = 0; i < 16; i++) begin
      wb_read(reg_idx_t'(i), w);
      check_word(w, '0, $sformatf("register %0d after reset", i));
    end
  endtask

  task automatic settings_readback();
    wb_word_t v;
    wb_word_t w;
    v = $urandom;
    wb_write(reg_mux_lo, v);
    wb_read(reg_mux_lo, w);
    check_word(w, v, "mux low readback");
    check_word(mux_control_o[31:0], v, "mux low port");
    v = $urandom;
    wb_write(reg_mux_hi, v);
    wb_read(reg_mux_hi, w);
    check_word(w, {16'b0, v[15:0]}, "mux high readback");
    check_word({16'b0, mux_control_o[47:32]}, {16'b0, v[15:0]}, "mux high port");
    v = $urandom;
    wb_write(reg_three_bit, v);
    wb_read(reg_three_bit, w);
    check_word(w, {31'b0, v[0]}, "three-bit readback");
    check_word({31'b0, is_three_bit_o}, {31'b0, v[0]}, "three-bit port");
    // Shift reset set, offsets stay at zero
    v = $urandom | 32'h8000_0000;
    wb_write(reg_delay, v);
    wb_read(reg_delay, w);
    check_word(w, {v[31], 7'b0, v[23:0]}, "delay readback");
    v = $urandom;
    wb_write(reg_error, v);
    @(negedge user_clk);
    check_mask(induce_error_o, v[11:0], "error pulse");
    @(negedge user_clk);
    check_mask(induce_error_o, '0, "error pulse end");
    wb_read(reg_error, w);
    check_word(w, {20'b0, v[11:0]}, "error mask readback");
    // Unmapped index ignores the write
    v = $urandom;
    wb_write(4'd11, v);
    wb_read(4'd11, w);
    check_word(w, '0, "unmapped index");
  endtask

  task automatic read_accesses();
    logic [31:0] r;
    lane_mask_t  lk;
    wb_word_t    w;
    for (int n = 0; n < n_access; n++) begin
      r  = $urandom;
      lk = rnd_mask();
      @(posedge user_clk);
      locked_i <= lk;
      // Write bit random, read strobe must win
      wb_write(reg_control, {1'b0, r[27:16], r[28], 1'b1, r[29], r[15:8], r[7:0]});
      wait_idle();
      wb_read(reg_control, w);
      check_word(w, ctl_status_word(1'b0, lk, dts_model_byte(r[15:8], r[27:16])),
                 "control status after read");
      expect_access(pack_access(1'b1, 1'b0, r[27:16], r[15:8], r[7:0]), "read access");
      check_word({31'b0, unmute_o}, {31'b0, r[28]}, "unmute level");
    end
  endtask

  task automatic write_accesses();
    logic [31:0] r;
    for (int n = 0; n < n_access; n++) begin
      r = $urandom;
      wb_write(reg_control, {1'b0, r[27:16], r[28], 1'b0, 1'b1, r[15:8], r[7:0]});
      wait_idle();
      expect_access(pack_access(1'b0, 1'b1, r[27:16], r[15:8], r[7:0]), "write access");
    end
  endtask

  task automatic held_control_write();
    logic [31:0] r1;
    logic [31:0] r2;
    int unsigned a1;
    wb_word_t    w;
    r1 = $urandom;
    r2 = $urandom;
    wb_write(reg_control, {1'b0, r1[27:16], 1'b0, 1'b1, 1'b0, r1[15:8], r1[7:0]});
    a1 = last_ack;
    wb_write(reg_control, {1'b0, r2[27:16], 1'b0, 1'b0, 1'b1, r2[15:8], r2[7:0]});
    // Busy spans setup, strobes and hold, then one edge to the ack
    check_word(wb_word_t'(last_ack - a1), wb_word_t'(strobe_len + 4), "held write ack spacing");
    wait_idle();
    expect_access(pack_access(1'b1, 1'b0, r1[27:16], r1[15:8], r1[7:0]), "first queued access");
    expect_access(pack_access(1'b0, 1'b1, r2[27:16], r2[15:8], r2[7:0]), "second queued access");
    if (acc_q.size() != 0) begin
      $display("Extra deformatter access after the held write at %0t ns", $time);
      fail_run();
    end
    wb_read(reg_control, w);
    check_word({24'b0, w[7:0]}, {24'b0, dts_model_byte(r1[15:8], r1[27:16])},
               "byte from first queued access");
  endtask

  task automatic compare_offsets();
    wb_word_t w;
    for (int k = 0; k < 3; k++) begin
      wb_read(reg_idx_t'(reg_offset0 + k), w);
      for (int b = 0; b < 4; b++) begin
        check_offset(w[8*b +: 8], model_off[4*k + b], $sformatf("offset of lane %0d", 4*k + b));
      end
    end
  endtask

  task automatic lane_offset_walk();
    lane_mask_t adv;
    lane_mask_t dly;
    logic       rst;
    for (int i = 0; i < num_lanes; i++) begin
      model_off[i] = '0;
    end
    for (int n = 0; n < n_lane_steps; n++) begin
      if (n < 200) begin
        // Mostly delay, lanes pile up at the top rail
        adv = rnd_mask() & rnd_mask() & rnd_mask();
        dly = ~(rnd_mask() & rnd_mask() & rnd_mask());
        rst = 1'b0;
      end else if (n < 560) begin
        // Mostly advance, down through zero to the bottom rail
        adv = ~(rnd_mask() & rnd_mask() & rnd_mask());
        dly = rnd_mask() & rnd_mask() & rnd_mask();
        rst = 1'b0;
      end else begin
        adv = rnd_mask();
        dly = rnd_mask();
        rst = (($urandom % 8) == 0);
      end
      wb_write(reg_delay, {rst, 7'b0, dly, adv});
      for (int i = 0; i < num_lanes; i++) begin
        model_off[i] = next_offset(model_off[i], adv[i], dly[i], rst);
      end
      // Pulses in the cycle after the ack, gone the cycle after
      @(negedge user_clk);
      check_mask(shift_advance_o, adv, "advance pulse");
      check_mask(shift_delay_o, dly, "delay pulse");
      check_mask(lane_mask_t'(shift_rst_o), lane_mask_t'(rst), "shift reset pulse");
      @(negedge user_clk);
      check_mask(shift_advance_o, '0, "advance pulse end");
      check_mask(shift_delay_o, '0, "delay pulse end");
      check_mask(lane_mask_t'(shift_rst_o), '0, "shift reset pulse end");
      if (n % 4 == 3) begin
        compare_offsets();
      end
    end
  endtask

  initial begin
    void'($urandom(32'h6e797f32));
    wb_rst_i <= 1'b1;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    wb_adr_i <= '0;
    wb_sel_i <= '0;
    wb_dat_i <= '0;
    locked_i <= '0;
    repeat (2) @(posedge user_clk);
    wb_rst_i <= 1'b0;
    verify_reset_state();
    settings_readback();
    read_accesses();
    write_accesses();
    held_control_write();
    lane_offset_walk();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
src/dts_attach_pkg.sv
src/wb_reg_slave.sv
src/dts_ctl_port.sv
src/lane_align_ctrl.sv
src/wb_dts_attach.sv
verification/tb_wb_dts_attach.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
  --top-module tb_wb_dts_attach --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  echo "Failure found in sim.log"
  exit 1
fi
exit 0
